// File: logic/board_regs_pkg.sv
// board control register map
// data and address widths, port count, firmware type word

package board_regs_pkg;

    //----------------------------------------
    // widths and counts
    //----------------------------------------
    localparam int REG_DW           = 16;
    localparam int REG_AW           = 7;
    localparam int ETH_PORTS        = 4;
    localparam int TEST_ARRAY_COUNT = 8;

    typedef logic [REG_DW-1:0] reg_data_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // identifies this build variant to host software
    localparam reg_data_t FW_TYPE = 16'h00B4;

    //----------------------------------------
    // address map, shared by reads and writes
    //----------------------------------------
    // read only
    localparam reg_addr_t ADDR_FW_DATE_LO   = 7'h00;
    localparam reg_addr_t ADDR_FW_DATE_HI   = 7'h01;
    localparam reg_addr_t ADDR_FW_TIME_LO   = 7'h02;
    localparam reg_addr_t ADDR_FW_TIME_HI   = 7'h03;
    localparam reg_addr_t ADDR_FW_TYPE      = 7'h04;
    localparam reg_addr_t ADDR_MAC_LINK     = 7'h05;
    localparam reg_addr_t ADDR_RXERR_BASE   = 7'h06; // port n: lo at +2n, hi at +2n+1

    // read/write
    localparam reg_addr_t ADDR_PHY_RST      = 7'h0E;
    localparam reg_addr_t ADDR_MDIO_CLK     = 7'h0F;
    localparam reg_addr_t ADDR_MDIO_DATA_O  = 7'h10;
    localparam reg_addr_t ADDR_MDIO_DIR     = 7'h11; // 1 drives the pin
    localparam reg_addr_t ADDR_MDIO_DATA_I  = 7'h12; // pin readback, read only
    localparam reg_addr_t ADDR_ETH_RX_MASK  = 7'h13;

    // scratch words 20..27
    localparam reg_addr_t ADDR_TEST_ARRAY   = 7'h20;

endpackage

// File: logic/spi_frame_pkg.sv
// SPI frame layout
// frame and header length, rw bit position, field widths

package spi_frame_pkg;

    // frame is rw bit, address, data; MSB first
    localparam int FRAME_BITS      = 24;
    localparam int HDR_BITS        = 8;
    localparam int ADDR_BITS       = HDR_BITS - 1;
    localparam int DATA_BITS       = FRAME_BITS - HDR_BITS;

    // position of the rw bit in the full frame, 1 means read
    localparam int RW_BIT          = FRAME_BITS - 1;

    // bit counter must hold FRAME_BITS itself
    localparam int BIT_CNT_W       = $clog2(FRAME_BITS + 1);

    localparam int SPI_SYNC_STAGES = 2;

endpackage

// File: logic/spi_reg_slave.sv
// SPI slave bridging host frames to the register bank
// pin synchronizers, frame shifter, write strobe, read shifter

`timescale 1ns/1ps

module spi_reg_slave
    import board_regs_pkg::*, spi_frame_pkg::*;
(
    input  logic      clk125M,
    input  logic      reset_i,

    input  logic      spi_clk_i,
    input  logic      spi_cs_i,
    input  logic      spi_mosi_i,
    output logic      spi_miso_o,

    output logic      reg_wr_en_o,
    output reg_addr_t reg_wr_addr_o,
    output reg_data_t reg_wr_data_o,
    output reg_addr_t reg_rd_addr_o,
    input  reg_data_t reg_rd_data_i
);

    //----------------------------------------
    // pin synchronizers and edge detect
    //----------------------------------------
    logic [SPI_SYNC_STAGES-1:0] sclk_sync;
    logic [SPI_SYNC_STAGES-1:0] cs_sync;
    logic [SPI_SYNC_STAGES-1:0] mosi_sync;
    logic                       sclk_d;
    logic                       sclk_s;
    logic                       mosi_s;
    logic                       cs_active;
    logic                       sclk_rise;
    logic                       sclk_fall;

    always_ff @(posedge clk125M) begin
        if (reset_i) begin
            sclk_sync <= '0;
            cs_sync   <= '1; // deselected
            mosi_sync <= '0;
            sclk_d    <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[SPI_SYNC_STAGES-2:0], spi_clk_i};
            cs_sync   <= {cs_sync[SPI_SYNC_STAGES-2:0], spi_cs_i};
            mosi_sync <= {mosi_sync[SPI_SYNC_STAGES-2:0], spi_mosi_i};
            sclk_d    <= sclk_s;
        end
    end

    assign sclk_s    = sclk_sync[SPI_SYNC_STAGES-1];
    assign mosi_s    = mosi_sync[SPI_SYNC_STAGES-1];
    assign cs_active = ~cs_sync[SPI_SYNC_STAGES-1];
    assign sclk_rise = cs_active & sclk_s & ~sclk_d;
    assign sclk_fall = cs_active & ~sclk_s & sclk_d;

    //----------------------------------------
    // frame shifter
    //----------------------------------------
    logic [FRAME_BITS-1:0] frame_sr;
    logic [FRAME_BITS-1:0] frame_next;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [DATA_BITS-1:0]  rd_sr;
    logic                  hdr_done;
    logic                  frame_done;
    logic                  data_phase;
    logic                  miso_q;
    logic                  wr_en_q;
    reg_addr_t             wr_addr_q;
    reg_data_t             wr_data_q;

    assign frame_next = {frame_sr[FRAME_BITS-2:0], mosi_s};
    assign hdr_done   = sclk_rise && (bit_cnt == BIT_CNT_W'(HDR_BITS - 1));
    assign frame_done = sclk_rise && (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));
    assign data_phase = bit_cnt >= BIT_CNT_W'(HDR_BITS);

    // control state
    always_ff @(posedge clk125M) begin
        if (reset_i) begin
            bit_cnt <= '0;
            wr_en_q <= 1'b0;
            miso_q  <= 1'b0;
        end else begin
            wr_en_q <= frame_done && !frame_next[RW_BIT]; // write command only
            if (!cs_active) begin
                bit_cnt <= '0; // short frames die here
                miso_q  <= 1'b0;
            end else begin
                if (sclk_rise && bit_cnt != BIT_CNT_W'(FRAME_BITS)) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
                if (sclk_fall && data_phase) begin
                    miso_q <= rd_sr[DATA_BITS-1];
                end
            end
        end
    end

    // payload
    always_ff @(posedge clk125M) begin
        if (sclk_rise && bit_cnt != BIT_CNT_W'(FRAME_BITS)) begin
            frame_sr <= frame_next;
        end
        if (hdr_done) begin
            rd_sr <= frame_next[HDR_BITS-1] ? reg_rd_data_i : '0; // latch read word
        end else if (sclk_fall && data_phase) begin
            rd_sr <= {rd_sr[DATA_BITS-2:0], 1'b0};
        end
        if (frame_done) begin
            wr_addr_q <= frame_next[RW_BIT-1 -: ADDR_BITS];
            wr_data_q <= frame_next[DATA_BITS-1:0];
        end
    end

    // address is valid in the cycle hdr_done fires
    assign reg_rd_addr_o = frame_next[ADDR_BITS-1:0];

    assign reg_wr_en_o   = wr_en_q;
    assign reg_wr_addr_o = wr_addr_q;
    assign reg_wr_data_o = wr_data_q;
    assign spi_miso_o    = miso_q;

endmodule

// File: logic/reg_bank.sv
// board register bank
// writable registers, scratch array, read mux, MDIO controls

`timescale 1ns/1ps

module reg_bank
    import board_regs_pkg::*;
#(
    parameter logic [31:0] FW_DATE = 32'h0,
    parameter logic [31:0] FW_TIME = 32'h0
) (
    input  logic                     clk125M,
    input  logic                     reset_i,

    input  logic                     reg_wr_en_i,
    input  reg_addr_t                reg_wr_addr_i,
    input  reg_data_t                reg_wr_data_i,
    input  reg_addr_t                reg_rd_addr_i,
    output reg_data_t                reg_rd_data_o,

    input  logic [ETH_PORTS-1:0]     mac_link_i,
    input  logic [ETH_PORTS*32-1:0]  rx_err_cnt_i,
    input  logic                     mdio_pin_i,

    output logic [ETH_PORTS-1:0]     eth_phy_rst_o,
    output logic                     eth_phy_mdc_o,
    output logic                     mdio_data_o,
    output logic                     mdio_oe_o,
    output logic [ETH_PORTS-1:0]     eth_rx_mask_o
);

    logic [ETH_PORTS-1:0] phy_rst_q;
    logic                 mdc_q;
    logic                 mdio_data_q;
    logic                 mdio_dir_q;
    logic [ETH_PORTS-1:0] rx_mask_q;
    reg_data_t            test_array [TEST_ARRAY_COUNT];
    logic                 mdio_meta;
    logic                 mdio_in_q;
    reg_data_t            rd_data;

    //----------------------------------------
    // write decode
    //----------------------------------------
    always_ff @(posedge clk125M) begin
        if (reset_i) begin
            phy_rst_q   <= '0;
            mdc_q       <= 1'b0;
            mdio_data_q <= 1'b0;
            mdio_dir_q  <= 1'b0; // pin released
            rx_mask_q   <= '0;
            for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
                test_array[i] <= '0;
            end
        end else if (reg_wr_en_i) begin
            case (reg_wr_addr_i)
                ADDR_PHY_RST:     phy_rst_q   <= reg_wr_data_i[ETH_PORTS-1:0];
                ADDR_MDIO_CLK:    mdc_q       <= reg_wr_data_i[0];
                ADDR_MDIO_DATA_O: mdio_data_q <= reg_wr_data_i[0];
                ADDR_MDIO_DIR:    mdio_dir_q  <= reg_wr_data_i[0];
                ADDR_ETH_RX_MASK: rx_mask_q   <= reg_wr_data_i[ETH_PORTS-1:0];
                default: ; // read only or unmapped
            endcase
            for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
                if (reg_wr_addr_i == ADDR_TEST_ARRAY + reg_addr_t'(i)) begin
                    test_array[i] <= reg_wr_data_i;
                end
            end
        end
    end

    // MDIO pin comes from the PHY, async to us
    always_ff @(posedge clk125M) begin
        mdio_meta <= mdio_pin_i;
        mdio_in_q <= mdio_meta;
    end

    //----------------------------------------
    // read mux
    //----------------------------------------
    always_comb begin
        rd_data = '0;
        case (reg_rd_addr_i)
            ADDR_FW_DATE_LO:  rd_data = FW_DATE[REG_DW-1:0];
            ADDR_FW_DATE_HI:  rd_data = FW_DATE[2*REG_DW-1:REG_DW];
            ADDR_FW_TIME_LO:  rd_data = FW_TIME[REG_DW-1:0];
            ADDR_FW_TIME_HI:  rd_data = FW_TIME[2*REG_DW-1:REG_DW];
            ADDR_FW_TYPE:     rd_data = FW_TYPE;
            ADDR_MAC_LINK:    rd_data = reg_data_t'(mac_link_i);
            ADDR_PHY_RST:     rd_data = reg_data_t'(phy_rst_q);
            ADDR_MDIO_CLK:    rd_data = reg_data_t'(mdc_q);
            ADDR_MDIO_DATA_O: rd_data = reg_data_t'(mdio_data_q);
            ADDR_MDIO_DIR:    rd_data = reg_data_t'(mdio_dir_q);
            ADDR_MDIO_DATA_I: rd_data = reg_data_t'(mdio_in_q);
            ADDR_ETH_RX_MASK: rd_data = reg_data_t'(rx_mask_q);
            default: ;
        endcase
        // error counters, two halves per port
        for (int n = 0; n < ETH_PORTS; n++) begin
            if (reg_rd_addr_i == ADDR_RXERR_BASE + reg_addr_t'(2 * n)) begin
                rd_data = rx_err_cnt_i[32*n +: REG_DW];
            end
            if (reg_rd_addr_i == ADDR_RXERR_BASE + reg_addr_t'(2 * n + 1)) begin
                rd_data = rx_err_cnt_i[32*n+REG_DW +: REG_DW];
            end
        end
        for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
            if (reg_rd_addr_i == ADDR_TEST_ARRAY + reg_addr_t'(i)) begin
                rd_data = test_array[i];
            end
        end
    end

    assign reg_rd_data_o = rd_data;
    assign eth_phy_rst_o = phy_rst_q;
    assign eth_phy_mdc_o = mdc_q;
    assign mdio_data_o   = mdio_data_q;
    assign mdio_oe_o     = mdio_dir_q;
    assign eth_rx_mask_o = rx_mask_q;

endmodule

// File: logic/led_blinker.sv
// LED blinker
// microsecond and millisecond prescaler chain driving a toggle

`timescale 1ns/1ps

module led_blinker #(
    parameter int CLK_HALF_US   = 62,  // clocks per half microsecond
    parameter int BLINK_HALF_MS = 125  // ms per LED level
) (
    input  logic clk125M,
    input  logic reset_i,
    output logic dbg_led_o
);

    localparam int US_DIV = 2 * CLK_HALF_US;
    localparam int MS_DIV = 1000;
    localparam int US_W   = $clog2(US_DIV + 1);
    localparam int MS_W   = $clog2(MS_DIV + 1);
    localparam int BL_W   = $clog2(BLINK_HALF_MS + 1);

    logic [US_W-1:0] us_cnt;
    logic [MS_W-1:0] ms_cnt;
    logic [BL_W-1:0] blink_cnt;
    logic            us_tick;
    logic            ms_tick;
    logic            led_q;

    assign us_tick = us_cnt == US_W'(US_DIV - 1);
    assign ms_tick = us_tick && (ms_cnt == MS_W'(MS_DIV - 1));

    always_ff @(posedge clk125M) begin
        if (reset_i) begin
            us_cnt    <= '0;
            ms_cnt    <= '0;
            blink_cnt <= '0;
            led_q     <= 1'b0;
        end else begin
            us_cnt <= us_tick ? '0 : us_cnt + 1'b1;
            if (us_tick) begin
                ms_cnt <= ms_tick ? '0 : ms_cnt + 1'b1;
            end
            if (ms_tick) begin
                if (blink_cnt == BL_W'(BLINK_HALF_MS - 1)) begin
                    blink_cnt <= '0;
                    led_q     <= ~led_q; // half period done
                end else begin
                    blink_cnt <= blink_cnt + 1'b1;
                end
            end
        end
    end

    assign dbg_led_o = led_q;

endmodule

// File: logic/board_ctrl_top.sv
// board control top level
// SPI register slave, register bank, LED blinker, MDIO tristate

`timescale 1ns/1ps

module board_ctrl_top
    import board_regs_pkg::*;
#(
    parameter logic [31:0] FW_DATE           = 32'h0000_0000,
    parameter logic [31:0] FW_TIME           = 32'h0000_0000,
    parameter int          LED_CLK_HALF_US   = 62,
    parameter int          LED_BLINK_HALF_MS = 125
) (
    input  logic                    clk125M,
    input  logic                    reset_i,

    input  logic                    spi_clk_i,
    input  logic                    spi_cs_i,
    input  logic                    spi_mosi_i,
    output logic                    spi_miso_o,

    input  logic [ETH_PORTS-1:0]    mac_link_i,
    input  logic [ETH_PORTS*32-1:0] rx_err_cnt_i,

    inout  wire                     eth_phy_mdio,
    output logic [ETH_PORTS-1:0]    eth_phy_rst_o,
    output logic                    eth_phy_mdc_o,
    output logic [ETH_PORTS-1:0]    eth_rx_mask_o,

    output logic                    dbg_led_o
);

    logic      reg_wr_en;
    reg_addr_t reg_wr_addr;
    reg_data_t reg_wr_data;
    reg_addr_t reg_rd_addr;
    reg_data_t reg_rd_data;
    logic      slave_miso;
    logic      mdio_data;
    logic      mdio_oe;

    spi_reg_slave u_spi (
        .clk125M       (clk125M),
        .reset_i       (reset_i),
        .spi_clk_i     (spi_clk_i),
        .spi_cs_i      (spi_cs_i),
        .spi_mosi_i    (spi_mosi_i),
        .spi_miso_o    (slave_miso),
        .reg_wr_en_o   (reg_wr_en),
        .reg_wr_addr_o (reg_wr_addr),
        .reg_wr_data_o (reg_wr_data),
        .reg_rd_addr_o (reg_rd_addr),
        .reg_rd_data_i (reg_rd_data)
    );

    reg_bank #(
        .FW_DATE (FW_DATE),
        .FW_TIME (FW_TIME)
    ) u_regs (
        .clk125M       (clk125M),
        .reset_i       (reset_i),
        .reg_wr_en_i   (reg_wr_en),
        .reg_wr_addr_i (reg_wr_addr),
        .reg_wr_data_i (reg_wr_data),
        .reg_rd_addr_i (reg_rd_addr),
        .reg_rd_data_o (reg_rd_data),
        .mac_link_i    (mac_link_i),
        .rx_err_cnt_i  (rx_err_cnt_i),
        .mdio_pin_i    (eth_phy_mdio),
        .eth_phy_rst_o (eth_phy_rst_o),
        .eth_phy_mdc_o (eth_phy_mdc_o),
        .mdio_data_o   (mdio_data),
        .mdio_oe_o     (mdio_oe),
        .eth_rx_mask_o (eth_rx_mask_o)
    );

    led_blinker #(
        .CLK_HALF_US   (LED_CLK_HALF_US),
        .BLINK_HALF_MS (LED_BLINK_HALF_MS)
    ) u_led (
        .clk125M   (clk125M),
        .reset_i   (reset_i),
        .dbg_led_o (dbg_led_o)
    );

    // idle high while deselected
    assign spi_miso_o   = spi_cs_i | slave_miso;
    assign eth_phy_mdio = mdio_oe ? mdio_data : 1'bz;

endmodule

// File: test/spi_host_tasks.svh
// SPI host tasks for the board control testbench
// mode 0 frames: rw bit, 7 bit address, 16 bit data, MSB first

`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

localparam int SPI_HOLD_CLKS = 10; // clk125M cycles per SPI level

task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk125M);
endtask

//----------------------------------------
// one complete frame
//----------------------------------------
// MISO is sampled on the falling clk125M edge just before each rising SCLK
task automatic spi_transfer(
    input  logic      rd,
    input  reg_addr_t addr,
    input  reg_data_t wdata,
    output reg_data_t rdata
);
    logic [FRAME_BITS-1:0] frame;
    reg_data_t             shift_in;

    frame    = {rd, addr, wdata};
    shift_in = '0;

    @(posedge clk125M);
    spi_cs_i <= 1'b0;
    wait_clocks(SPI_HOLD_CLKS);
    for (int i = FRAME_BITS - 1; i >= 0; i--) begin
        spi_clk_i  <= 1'b0;
        spi_mosi_i <= frame[i];
        wait_clocks(SPI_HOLD_CLKS - 1);
        @(negedge clk125M);
        if (i < DATA_BITS) begin
            shift_in = {shift_in[DATA_BITS-2:0], spi_miso_o}; // data phase only
        end
        @(posedge clk125M);
        spi_clk_i <= 1'b1;
        wait_clocks(SPI_HOLD_CLKS);
    end
    spi_clk_i <= 1'b0;
    wait_clocks(SPI_HOLD_CLKS);
    spi_cs_i   <= 1'b1;
    spi_mosi_i <= 1'b0;
    wait_clocks(SPI_HOLD_CLKS);
    rdata = shift_in;
endtask

task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    reg_data_t unused;
    spi_transfer(1'b0, addr, data, unused);
endtask

task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
    spi_transfer(1'b1, addr, '0, data);
endtask

`endif

// File: test/board_ctrl_tb.sv
// board control testbench
// SPI register access, MDIO pin, PHY controls and LED timing

`timescale 1ns/1ps

module board_ctrl_tb
    import board_regs_pkg::*, spi_frame_pkg::*;
();

    localparam logic [31:0] FW_DATE           = 32'h2024_0315;
    localparam logic [31:0] FW_TIME           = 32'h0012_3456;
    localparam int          LED_CLK_HALF_US   = 1;
    localparam int          LED_BLINK_HALF_MS = 1;
    localparam int          LED_HALF_CLKS     = 2 * LED_CLK_HALF_US * 1000 * LED_BLINK_HALF_MS;

    // 16 scratch + 17 read-only + 8 MDIO + 6 control frames
    localparam int NUM_FRAMES    = 47;
    localparam int WATCHDOG_CLKS = 2 * (NUM_FRAMES * FRAME_BITS * 20 + 3 * 2 * LED_HALF_CLKS);

    logic                    clk125M = 1'b0;
    logic                    reset_i;
    logic                    spi_clk_i;
    logic                    spi_cs_i;
    logic                    spi_mosi_i;
    logic                    spi_miso_o;
    logic [ETH_PORTS-1:0]    mac_link_i;
    logic [ETH_PORTS*32-1:0] rx_err_cnt_i;
    wire                     eth_phy_mdio;
    logic [ETH_PORTS-1:0]    eth_phy_rst_o;
    logic                    eth_phy_mdc_o;
    logic [ETH_PORTS-1:0]    eth_rx_mask_o;
    logic                    dbg_led_o;
    logic                    mdio_drive;
    integer                  seed;
    reg_data_t               scratch [TEST_ARRAY_COUNT];

    assign (weak1, weak0) eth_phy_mdio = mdio_drive; // PHY side pull

    always #4 clk125M = ~clk125M;

    board_ctrl_top #(
        .FW_DATE           (FW_DATE),
        .FW_TIME           (FW_TIME),
        .LED_CLK_HALF_US   (LED_CLK_HALF_US),
        .LED_BLINK_HALF_MS (LED_BLINK_HALF_MS)
    ) dut (
        .clk125M       (clk125M),
        .reset_i       (reset_i),
        .spi_clk_i     (spi_clk_i),
        .spi_cs_i      (spi_cs_i),
        .spi_mosi_i    (spi_mosi_i),
        .spi_miso_o    (spi_miso_o),
        .mac_link_i    (mac_link_i),
        .rx_err_cnt_i  (rx_err_cnt_i),
        .eth_phy_mdio  (eth_phy_mdio),
        .eth_phy_rst_o (eth_phy_rst_o),
        .eth_phy_mdc_o (eth_phy_mdc_o),
        .eth_rx_mask_o (eth_rx_mask_o),
        .dbg_led_o     (dbg_led_o)
    );

    `include "spi_host_tasks.svh"

    //----------------------------------------
    // checking
    //----------------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h",
                 $time, name, expected, actual);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    task automatic check_read(input reg_addr_t addr, input reg_data_t expected,
                              input string name);
        reg_data_t value;
        reg_read(addr, value);
        check_equal(name, expected, value);
    endtask

    //----------------------------------------
    // stimulus
    //----------------------------------------
    initial begin
        reg_data_t wdata;
        logic      last_led;
        int        cycles;

        seed = 32'hef5d_5be5;
        reset_i      <= 1'b1;
        spi_clk_i    <= 1'b0;
        spi_cs_i     <= 1'b1;
        spi_mosi_i   <= 1'b0;
        mac_link_i   <= $random(seed);
        rx_err_cnt_i <= {$random(seed), $random(seed), $random(seed), $random(seed)};
        mdio_drive   <= 1'b1;
        wait_clocks(16);
        reset_i <= 1'b0;
        wait_clocks(2);

        // reset state, MDIO pin follows the pull only
        @(negedge clk125M);
        check_equal("eth_phy_rst_o", 0, eth_phy_rst_o);
        check_equal("eth_phy_mdc_o", 0, eth_phy_mdc_o);
        check_equal("eth_rx_mask_o", 0, eth_rx_mask_o);
        check_equal("dbg_led_o", 0, dbg_led_o);
        check_equal("spi_miso_o", 1, spi_miso_o); // idle high while deselected
        check_equal("eth_phy_mdio", 1, eth_phy_mdio);
        @(posedge clk125M);
        mdio_drive <= 1'b0;
        @(negedge clk125M);
        check_equal("eth_phy_mdio", 0, eth_phy_mdio);

        // scratch array
        for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
            wdata = $random(seed);
            scratch[i] = wdata;
            reg_write(ADDR_TEST_ARRAY + reg_addr_t'(i), wdata);
        end
        for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
            check_read(ADDR_TEST_ARRAY + reg_addr_t'(i), scratch[i],
                       $sformatf("test_array[%0d]", i));
        end

        // read-only words
        check_read(ADDR_FW_DATE_LO, FW_DATE[15:0], "fw_date_lo");
        check_read(ADDR_FW_DATE_HI, FW_DATE[31:16], "fw_date_hi");
        check_read(ADDR_FW_TIME_LO, FW_TIME[15:0], "fw_time_lo");
        check_read(ADDR_FW_TIME_HI, FW_TIME[31:16], "fw_time_hi");
        check_read(ADDR_FW_TYPE, FW_TYPE, "fw_type");
        check_read(ADDR_MAC_LINK, reg_data_t'(mac_link_i), "mac_link");
        for (int n = 0; n < ETH_PORTS; n++) begin
            check_read(ADDR_RXERR_BASE + reg_addr_t'(2 * n), rx_err_cnt_i[32*n +: 16],
                       $sformatf("rx_err_cnt[%0d] lo", n));
            check_read(ADDR_RXERR_BASE + reg_addr_t'(2 * n + 1), rx_err_cnt_i[32*n+16 +: 16],
                       $sformatf("rx_err_cnt[%0d] hi", n));
        end
        check_read(7'h1A, 16'h0000, "unmapped 1a");
        reg_write(ADDR_FW_TYPE, ~FW_TYPE);
        check_read(ADDR_FW_TYPE, FW_TYPE, "fw_type after write");

        // MDIO driven by the DUT, pull set to the opposite level
        reg_write(ADDR_MDIO_DIR, 16'h0001);
        for (int b = 1; b >= 0; b--) begin
            @(posedge clk125M);
            mdio_drive <= (b == 0);
            reg_write(ADDR_MDIO_DATA_O, reg_data_t'(b));
            @(negedge clk125M);
            check_equal("eth_phy_mdio", b, eth_phy_mdio);
            check_read(ADDR_MDIO_DATA_O, reg_data_t'(b), "mdio_data_o");
        end

        // MDIO released, pin level reads back
        reg_write(ADDR_MDIO_DIR, 16'h0000);
        for (int b = 1; b >= 0; b--) begin
            @(posedge clk125M);
            mdio_drive <= (b == 1);
            wait_clocks(4);
            check_read(ADDR_MDIO_DATA_I, reg_data_t'(b), "mdio_data_i");
        end

        // PHY controls
        wdata = $random(seed);
        reg_write(ADDR_PHY_RST, wdata);
        @(negedge clk125M);
        check_equal("eth_phy_rst_o", wdata[ETH_PORTS-1:0], eth_phy_rst_o);
        check_read(ADDR_PHY_RST, reg_data_t'(wdata[ETH_PORTS-1:0]), "phy_rst readback");
        wdata = $random(seed) | 1;
        reg_write(ADDR_MDIO_CLK, wdata);
        @(negedge clk125M);
        check_equal("eth_phy_mdc_o", wdata[0], eth_phy_mdc_o);
        check_read(ADDR_MDIO_CLK, reg_data_t'(wdata[0]), "mdio_clk readback");
        wdata = $random(seed);
        reg_write(ADDR_ETH_RX_MASK, wdata);
        @(negedge clk125M);
        check_equal("eth_rx_mask_o", wdata[ETH_PORTS-1:0], eth_rx_mask_o);
        check_read(ADDR_ETH_RX_MASK, reg_data_t'(wdata[ETH_PORTS-1:0]), "rx_mask readback");

        // LED intervals, counted from one toggle to the next
        @(negedge clk125M);
        last_led = dbg_led_o;
        while (dbg_led_o === last_led) @(negedge clk125M);
        for (int t = 0; t < 3; t++) begin
            last_led = dbg_led_o;
            cycles   = 0;
            while (dbg_led_o === last_led) begin
                @(negedge clk125M);
                cycles++;
            end
            check_equal("dbg_led_o interval", LED_HALF_CLKS, cycles);
        end

        $display("=== PASS ===");
        $finish;
    end

    //----------------------------------------
    // watchdog
    //----------------------------------------
    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk125M);
        $display("Timeout: run did not finish within %0d clocks", WATCHDOG_CLKS);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: board_ctrl.f
+incdir+test
logic/board_regs_pkg.sv
logic/spi_frame_pkg.sv
logic/spi_reg_slave.sv
logic/reg_bank.sv
logic/led_blinker.sv
logic/board_ctrl_top.sv
test/board_ctrl_tb.sv
